/* logic/rd_mux_pkg.sv */
// read-port concentrator
// shared widths, depths and beat layouts

package rd_mux_pkg;

    // ==================================================
    // AXI field widths
    // ==================================================
    localparam int addr_w = 64;
    localparam int data_w = 64;
    localparam int id_w   = 4;
    localparam int len_w  = 8;
    localparam int size_w = 3;
    localparam int resp_w = 2;

    // ==================================================
    // queue depths
    // ==================================================
    localparam int cmd_depth   = 8;
    localparam int order_depth = 16;
    localparam int ret_depth   = 32;

    // room for beats still in flight behind the registered rready
    localparam int ret_afull_level = ret_depth - 4;

    typedef enum logic {
        chan_knl = 1'b0,
        chan_mmu = 1'b1
    } chan_e;

    typedef enum logic [resp_w-1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } resp_e;

    // one accepted read command
    typedef struct packed {
        chan_e               chan;
        logic [id_w-1:0]     id;
        logic [len_w-1:0]    len;
        logic [size_w-1:0]   size;
        logic [addr_w-1:0]   addr;
    } cmd_t;

    // one read data beat on its way back to a master
    typedef struct packed {
        logic [id_w-1:0]     id;
        resp_e               resp;
        logic                last;
        logic [data_w-1:0]   data;
    } beat_t;

endpackage

/* logic/sync_fifo.sv */
// single-clock show-ahead FIFO

module sync_fifo #(
    parameter int width = 8,
    parameter int depth = 16
) (
    input  logic                         aclk,
    input  logic                         areset,
    input  logic                         push,
    input  logic [width-1:0]             wdata,
    input  logic                         pop,
    output logic [width-1:0]             rdata,
    output logic                         empty,
    output logic                         full,
    output logic [$clog2(depth+1)-1:0]   count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    // a push into a full queue or a pop from an empty one is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign empty = (count == '0);
    assign full  = (count == cnt_w'(depth));

    // head stays visible while the queue holds data
    assign rdata = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge aclk or posedge areset) begin
        if (areset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/ar_arbiter.sv */
// read address round-robin arbiter

module ar_arbiter (
    input  logic                            aclk,
    input  logic                            areset,
    input  logic [rd_mux_pkg::id_w-1:0]     knl_arid,
    input  logic [rd_mux_pkg::addr_w-1:0]   knl_araddr,
    input  logic [rd_mux_pkg::len_w-1:0]    knl_arlen,
    input  logic [rd_mux_pkg::size_w-1:0]   knl_arsize,
    input  logic                            knl_arvalid,
    output logic                            knl_arready,
    input  logic [rd_mux_pkg::id_w-1:0]     mmu_arid,
    input  logic [rd_mux_pkg::addr_w-1:0]   mmu_araddr,
    input  logic [rd_mux_pkg::len_w-1:0]    mmu_arlen,
    input  logic [rd_mux_pkg::size_w-1:0]   mmu_arsize,
    input  logic                            mmu_arvalid,
    output logic                            mmu_arready,
    input  logic                            cmd_afull,
    output logic                            cmd_push,
    output rd_mux_pkg::cmd_t                cmd
);

    import rd_mux_pkg::*;

    logic [1:0] req_q;
    logic       grant;
    logic       grant_d1;
    logic       grant_d2;
    chan_e      rr_ptr;
    chan_e      win;
    chan_e      win_q;

    // ==================================================
    // request sampling and grant
    // ==================================================
    // no grant for two cycles after one, so stale samples never win
    assign grant = (|req_q) && !cmd_afull && !grant_d1 && !grant_d2;

    // preferred channel wins if it asks, else the other one
    always_comb begin
        if (req_q[rr_ptr]) begin
            win = rr_ptr;
        end else begin
            win = (rr_ptr == chan_knl) ? chan_mmu : chan_knl;
        end
    end

    always_ff @(posedge aclk or posedge areset) begin
        if (areset) begin
            req_q    <= '0;
            grant_d1 <= 1'b0;
            grant_d2 <= 1'b0;
            rr_ptr   <= chan_knl;
            win_q    <= chan_knl;
        end else begin
            req_q    <= {mmu_arvalid, knl_arvalid};
            grant_d1 <= grant;
            grant_d2 <= grant_d1;
            if (grant) begin
                win_q  <= win;
                rr_ptr <= (win == chan_knl) ? chan_mmu : chan_knl;
            end
        end
    end

    // ==================================================
    // accept cycle
    // ==================================================
    assign knl_arready = grant_d1 && (win_q == chan_knl);
    assign mmu_arready = grant_d1 && (win_q == chan_mmu);
    assign cmd_push    = grant_d1;

    // winner still holds its request fields here
    always_comb begin
        cmd.chan = win_q;
        if (win_q == chan_mmu) begin
            cmd.id   = mmu_arid;
            cmd.len  = mmu_arlen;
            cmd.size = mmu_arsize;
            cmd.addr = mmu_araddr;
        end else begin
            cmd.id   = knl_arid;
            cmd.len  = knl_arlen;
            cmd.size = knl_arsize;
            cmd.addr = knl_araddr;
        end
    end

endmodule

/* logic/ar_issue.sv */
// command queue and DDR address issue

module ar_issue (
    input  logic                            aclk,
    input  logic                            areset,
    input  logic                            cmd_push,
    input  rd_mux_pkg::cmd_t                cmd,
    output logic                            cmd_afull,
    output logic [rd_mux_pkg::id_w-1:0]     ddr_arid,
    output logic [rd_mux_pkg::addr_w-1:0]   ddr_araddr,
    output logic [rd_mux_pkg::len_w-1:0]    ddr_arlen,
    output logic [rd_mux_pkg::size_w-1:0]   ddr_arsize,
    output logic                            ddr_arvalid,
    input  logic                            ddr_arready,
    output logic                            order_valid,
    output rd_mux_pkg::chan_e               order_chan,
    input  logic                            order_pop
);

    import rd_mux_pkg::*;

    cmd_t                             cmd_head;
    logic                             cmd_empty;
    logic [$clog2(cmd_depth+1)-1:0]   cmd_count;
    logic                             ar_fire;
    logic [0:0]                       order_head;
    logic                             order_empty;
    logic                             order_full;

    // ==================================================
    // command queue
    // ==================================================
    sync_fifo #(
        .width ($bits(cmd_t)),
        .depth (cmd_depth)
    ) u_cmd_fifo (
        .aclk   (aclk),
        .areset (areset),
        .push   (cmd_push),
        .wdata  (cmd),
        .pop    (ar_fire),
        .rdata  (cmd_head),
        .empty  (cmd_empty),
        .full   (),
        .count  (cmd_count)
    );

    // two free slots cover a grant still in its cool-down
    assign cmd_afull = int'(cmd_count) >= cmd_depth - 2;

    // head goes out once the return side can track it
    assign ddr_arvalid = !cmd_empty && !order_full;
    assign ar_fire     = ddr_arvalid && ddr_arready;

    assign ddr_arid   = cmd_head.id;
    assign ddr_araddr = cmd_head.addr;
    assign ddr_arlen  = cmd_head.len;
    assign ddr_arsize = cmd_head.size;

    // ==================================================
    // order of issued channels
    // ==================================================
    sync_fifo #(
        .width (1),
        .depth (order_depth)
    ) u_order_fifo (
        .aclk   (aclk),
        .areset (areset),
        .push   (ar_fire),
        .wdata  (cmd_head.chan),
        .pop    (order_pop),
        .rdata  (order_head),
        .empty  (order_empty),
        .full   (order_full),
        .count  ()
    );

    assign order_valid = !order_empty;
    assign order_chan  = chan_e'(order_head);

endmodule

/* logic/r_router.sv */
// read data return router

module r_router (
    input  logic                            aclk,
    input  logic                            areset,
    input  logic [rd_mux_pkg::id_w-1:0]     ddr_rid,
    input  logic [rd_mux_pkg::data_w-1:0]   ddr_rdata,
    input  logic [rd_mux_pkg::resp_w-1:0]   ddr_rresp,
    input  logic                            ddr_rlast,
    input  logic                            ddr_rvalid,
    output logic                            ddr_rready,
    input  logic                            order_valid,
    input  rd_mux_pkg::chan_e               order_chan,
    output logic                            order_pop,
    output logic [rd_mux_pkg::id_w-1:0]     knl_rid,
    output logic [rd_mux_pkg::data_w-1:0]   knl_rdata,
    output logic [rd_mux_pkg::resp_w-1:0]   knl_rresp,
    output logic                            knl_rlast,
    output logic                            knl_rvalid,
    input  logic                            knl_rready,
    output logic [rd_mux_pkg::id_w-1:0]     mmu_rid,
    output logic [rd_mux_pkg::data_w-1:0]   mmu_rdata,
    output logic [rd_mux_pkg::resp_w-1:0]   mmu_rresp,
    output logic                            mmu_rlast,
    output logic                            mmu_rvalid,
    input  logic                            mmu_rready
);

    import rd_mux_pkg::*;

    localparam int cnt_w = $clog2(ret_depth + 1);

    logic              r_fire;
    beat_t             beat_q;
    chan_e             beat_chan_q;
    logic              beat_wen_q;
    beat_t             knl_head;
    beat_t             mmu_head;
    logic              knl_empty;
    logic              mmu_empty;
    logic [cnt_w-1:0]  knl_count;
    logic [cnt_w-1:0]  mmu_count;

    // ==================================================
    // DDR side
    // ==================================================
    assign r_fire    = ddr_rvalid && ddr_rready;
    // head of the order queue moves on with the last beat
    assign order_pop = r_fire && ddr_rlast && order_valid;

    always_ff @(posedge aclk or posedge areset) begin
        if (areset) begin
            ddr_rready  <= 1'b0;
            beat_wen_q  <= 1'b0;
            beat_chan_q <= chan_knl;
        end else begin
            ddr_rready  <= (int'(knl_count) < ret_afull_level) &&
                           (int'(mmu_count) < ret_afull_level);
            beat_wen_q  <= r_fire;
            beat_chan_q <= order_chan;
        end
    end

    always_ff @(posedge aclk) begin
        beat_q.id   <= ddr_rid;
        beat_q.resp <= resp_e'(ddr_rresp);
        beat_q.last <= ddr_rlast;
        beat_q.data <= ddr_rdata;
    end

    // ==================================================
    // per-channel return queues
    // ==================================================
    sync_fifo #(.width($bits(beat_t)), .depth(ret_depth)) u_knl_ret (
        .aclk   (aclk),
        .areset (areset),
        .push   (beat_wen_q && (beat_chan_q == chan_knl)),
        .wdata  (beat_q),
        .pop    (knl_rvalid && knl_rready),
        .rdata  (knl_head),
        .empty  (knl_empty),
        .full   (),
        .count  (knl_count)
    );

    sync_fifo #(.width($bits(beat_t)), .depth(ret_depth)) u_mmu_ret (
        .aclk   (aclk),
        .areset (areset),
        .push   (beat_wen_q && (beat_chan_q == chan_mmu)),
        .wdata  (beat_q),
        .pop    (mmu_rvalid && mmu_rready),
        .rdata  (mmu_head),
        .empty  (mmu_empty),
        .full   (),
        .count  (mmu_count)
    );

    assign knl_rvalid = !knl_empty;
    assign knl_rid    = knl_head.id;
    assign knl_rresp  = knl_head.resp;
    assign knl_rlast  = knl_head.last;
    assign knl_rdata  = knl_head.data;

    assign mmu_rvalid = !mmu_empty;
    assign mmu_rid    = mmu_head.id;
    assign mmu_rresp  = mmu_head.resp;
    assign mmu_rlast  = mmu_head.last;
    assign mmu_rdata  = mmu_head.data;

endmodule

/* logic/rd_mux_top.sv */
// read-port concentrator top level

module rd_mux_top (
    input  logic                            aclk,
    input  logic                            areset,
    // kernel master
    input  logic [rd_mux_pkg::id_w-1:0]     knl_arid,
    input  logic [rd_mux_pkg::addr_w-1:0]   knl_araddr,
    input  logic [rd_mux_pkg::len_w-1:0]    knl_arlen,
    input  logic [rd_mux_pkg::size_w-1:0]   knl_arsize,
    input  logic                            knl_arvalid,
    output logic                            knl_arready,
    output logic [rd_mux_pkg::id_w-1:0]     knl_rid,
    output logic [rd_mux_pkg::data_w-1:0]   knl_rdata,
    output logic [rd_mux_pkg::resp_w-1:0]   knl_rresp,
    output logic                            knl_rlast,
    output logic                            knl_rvalid,
    input  logic                            knl_rready,
    // mmu master
    input  logic [rd_mux_pkg::id_w-1:0]     mmu_arid,
    input  logic [rd_mux_pkg::addr_w-1:0]   mmu_araddr,
    input  logic [rd_mux_pkg::len_w-1:0]    mmu_arlen,
    input  logic [rd_mux_pkg::size_w-1:0]   mmu_arsize,
    input  logic                            mmu_arvalid,
    output logic                            mmu_arready,
    output logic [rd_mux_pkg::id_w-1:0]     mmu_rid,
    output logic [rd_mux_pkg::data_w-1:0]   mmu_rdata,
    output logic [rd_mux_pkg::resp_w-1:0]   mmu_rresp,
    output logic                            mmu_rlast,
    output logic                            mmu_rvalid,
    input  logic                            mmu_rready,
    // shared DDR read port
    output logic [rd_mux_pkg::id_w-1:0]     ddr_arid,
    output logic [rd_mux_pkg::addr_w-1:0]   ddr_araddr,
    output logic [rd_mux_pkg::len_w-1:0]    ddr_arlen,
    output logic [rd_mux_pkg::size_w-1:0]   ddr_arsize,
    output logic                            ddr_arvalid,
    input  logic                            ddr_arready,
    input  logic [rd_mux_pkg::id_w-1:0]     ddr_rid,
    input  logic [rd_mux_pkg::data_w-1:0]   ddr_rdata,
    input  logic [rd_mux_pkg::resp_w-1:0]   ddr_rresp,
    input  logic                            ddr_rlast,
    input  logic                            ddr_rvalid,
    output logic                            ddr_rready
);

    import rd_mux_pkg::*;

    // ==================================================
    // links between the stages
    // ==================================================
    logic   cmd_push;
    cmd_t   cmd;
    logic   cmd_afull;
    logic   order_valid;
    chan_e  order_chan;
    logic   order_pop;

    // port and wire names line up one to one
    ar_arbiter u_ar_arbiter (.*);

    ar_issue u_ar_issue (.*);

    r_router u_r_router (.*);

endmodule

/* bench/tb_clock.sv */
// testbench clock source

module tb_clock #(
    parameter int period_ns = 8
) (
    output logic aclk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        aclk = 1'b0;
        forever begin
            #(period_ns / 2.0) aclk = ~aclk;
        end
    end

endmodule

/* bench/rd_mux_asserts.sv */
// protocol and ordering assertions

module rd_mux_asserts (
    input logic                            aclk,
    input logic                            areset,
    input logic                            knl_arvalid,
    input logic                            knl_arready,
    input logic                            mmu_arvalid,
    input logic                            mmu_arready,
    input logic [rd_mux_pkg::id_w-1:0]     ddr_arid,
    input logic [rd_mux_pkg::addr_w-1:0]   ddr_araddr,
    input logic [rd_mux_pkg::len_w-1:0]    ddr_arlen,
    input logic [rd_mux_pkg::size_w-1:0]   ddr_arsize,
    input logic                            ddr_arvalid,
    input logic                            ddr_arready,
    input logic                            ddr_rvalid,
    input logic                            ddr_rready,
    input logic                            order_valid,
    input logic [rd_mux_pkg::id_w-1:0]     knl_rid,
    input logic [rd_mux_pkg::data_w-1:0]   knl_rdata,
    input logic [rd_mux_pkg::resp_w-1:0]   knl_rresp,
    input logic                            knl_rlast,
    input logic                            knl_rvalid,
    input logic                            knl_rready,
    input logic [rd_mux_pkg::id_w-1:0]     mmu_rid,
    input logic [rd_mux_pkg::data_w-1:0]   mmu_rdata,
    input logic [rd_mux_pkg::resp_w-1:0]   mmu_rresp,
    input logic                            mmu_rlast,
    input logic                            mmu_rvalid,
    input logic                            mmu_rready,
    input logic                            knl_ret_push,
    input logic                            knl_ret_full,
    input logic                            mmu_ret_push,
    input logic                            mmu_ret_full
);

    timeunit 1ns;
    timeprecision 100ps;

    import rd_mux_pkg::*;

    int   fail_count = 0;
    logic last_win;
    logic have_win;

    // last_win is 1 when mmu took the latest grant
    always_ff @(posedge aclk or posedge areset) begin
        if (areset) begin
            last_win <= 1'b0;
            have_win <= 1'b0;
        end else if (knl_arready || mmu_arready) begin
            last_win <= mmu_arready;
            have_win <= 1'b1;
        end
    end

    // ==================================================
    // address side
    // ==================================================
    a_reset_low: assert property (@(posedge aclk) $fell(areset) |->
        !(knl_arready || mmu_arready || ddr_arvalid || ddr_rready || knl_rvalid || mmu_rvalid))
        else begin
            fail_count++;
            $error("control output high right after reset");
        end

    // arready comes two cycles after the sampled requests
    a_round_robin: assert property (@(posedge aclk) disable iff (areset)
        (knl_arready || mmu_arready) && have_win && $past(knl_arvalid, 2) &&
        $past(mmu_arvalid, 2) |-> (mmu_arready != last_win))
        else begin
            fail_count++;
            $error("same channel won twice while both requested");
        end

    a_ar_stable: assert property (@(posedge aclk) disable iff (areset)
        ddr_arvalid && !ddr_arready |=>
        ddr_arvalid && $stable({ddr_arid, ddr_araddr, ddr_arlen, ddr_arsize}))
        else begin
            fail_count++;
            $error("ddr address channel changed before ddr_arready");
        end

    // ==================================================
    // return side
    // ==================================================
    a_beat_ordered: assert property (@(posedge aclk) disable iff (areset)
        ddr_rvalid && ddr_rready |-> order_valid)
        else begin
            fail_count++;
            $error("ddr beat accepted with no issued burst");
        end

    a_knl_r_stable: assert property (@(posedge aclk) disable iff (areset)
        knl_rvalid && !knl_rready |=>
        knl_rvalid && $stable({knl_rid, knl_rdata, knl_rresp, knl_rlast}))
        else begin
            fail_count++;
            $error("knl read beat changed before knl_rready");
        end

    a_mmu_r_stable: assert property (@(posedge aclk) disable iff (areset)
        mmu_rvalid && !mmu_rready |=>
        mmu_rvalid && $stable({mmu_rid, mmu_rdata, mmu_rresp, mmu_rlast}))
        else begin
            fail_count++;
            $error("mmu read beat changed before mmu_rready");
        end

    a_knl_no_overflow: assert property (@(posedge aclk) disable iff (areset)
        knl_ret_push |-> !knl_ret_full)
        else begin
            fail_count++;
            $error("beat written into full knl return queue");
        end

    a_mmu_no_overflow: assert property (@(posedge aclk) disable iff (areset)
        mmu_ret_push |-> !mmu_ret_full)
        else begin
            fail_count++;
            $error("beat written into full mmu return queue");
        end

endmodule

bind rd_mux_top rd_mux_asserts u_rd_mux_asserts (
    .*,
    .knl_ret_push (u_r_router.u_knl_ret.push),
    .knl_ret_full (u_r_router.u_knl_ret.full),
    .mmu_ret_push (u_r_router.u_mmu_ret.push),
    .mmu_ret_full (u_r_router.u_mmu_ret.full)
);

/* bench/rd_mux_tb.sv */
// read-port concentrator testbench

module rd_mux_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rd_mux_pkg::*;

    localparam logic [31:0] seed = 32'had03_1b3b;
    localparam int bursts_per_master = 40;
    localparam int max_beats = 8;
    localparam int clk_period = 8;
    localparam int stall_margin = 40;
    localparam int knl_hold_cycles = 300;
    localparam longint watchdog_ns = longint'(2 * bursts_per_master) * max_beats *
                                     stall_margin * clk_period + knl_hold_cycles * clk_period;

    logic aclk;
    logic areset;
    // index 0 is knl, index 1 is mmu
    logic [1:0]              arvalid;
    logic [1:0]              arready;
    logic [1:0]              rvalid;
    logic [1:0]              rready;
    logic [1:0]              rlast;
    logic [1:0][id_w-1:0]    arid;
    logic [1:0][id_w-1:0]    rid;
    logic [1:0][addr_w-1:0]  araddr;
    logic [1:0][len_w-1:0]   arlen;
    logic [1:0][size_w-1:0]  arsize;
    logic [1:0][data_w-1:0]  rdata;
    logic [1:0][resp_w-1:0]  rresp;
    logic [id_w-1:0]         ddr_arid;
    logic [id_w-1:0]         ddr_rid;
    logic [addr_w-1:0]       ddr_araddr;
    logic [len_w-1:0]        ddr_arlen;
    logic [size_w-1:0]       ddr_arsize;
    logic [data_w-1:0]       ddr_rdata;
    logic [resp_w-1:0]       ddr_rresp;
    logic                    ddr_arvalid;
    logic                    ddr_arready;
    logic                    ddr_rvalid;
    logic                    ddr_rready;
    logic                    ddr_rlast;

    // expected beats as {id, last, data}
    logic [68:0] exp_knl[$];
    logic [68:0] exp_mmu[$];
    // accepted commands as {id, len, size, addr}
    logic [78:0] cmd_q[$];
    // bursts taken by the DDR model as {id, len, addr}
    logic [75:0] burst_q[$];
    int   errors = 0;
    logic hold_knl = 1'b0;

    tb_clock #(.period_ns(clk_period)) u_tb_clock (.aclk(aclk));

    rd_mux_top u_rd_mux_top (
        .aclk(aclk), .areset(areset),
        .knl_arid(arid[0]), .knl_araddr(araddr[0]), .knl_arlen(arlen[0]),
        .knl_arsize(arsize[0]), .knl_arvalid(arvalid[0]), .knl_arready(arready[0]),
        .knl_rid(rid[0]), .knl_rdata(rdata[0]), .knl_rresp(rresp[0]),
        .knl_rlast(rlast[0]), .knl_rvalid(rvalid[0]), .knl_rready(rready[0]),
        .mmu_arid(arid[1]), .mmu_araddr(araddr[1]), .mmu_arlen(arlen[1]),
        .mmu_arsize(arsize[1]), .mmu_arvalid(arvalid[1]), .mmu_arready(arready[1]),
        .mmu_rid(rid[1]), .mmu_rdata(rdata[1]), .mmu_rresp(rresp[1]),
        .mmu_rlast(rlast[1]), .mmu_rvalid(rvalid[1]), .mmu_rready(rready[1]),
        .ddr_arid(ddr_arid), .ddr_araddr(ddr_araddr), .ddr_arlen(ddr_arlen),
        .ddr_arsize(ddr_arsize), .ddr_arvalid(ddr_arvalid), .ddr_arready(ddr_arready),
        .ddr_rid(ddr_rid), .ddr_rdata(ddr_rdata), .ddr_rresp(ddr_rresp),
        .ddr_rlast(ddr_rlast), .ddr_rvalid(ddr_rvalid), .ddr_rready(ddr_rready)
    );

    task automatic check_field(input string sig, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            errors++;
            $display("error at %0d ns: %s expected %0h got %0h", $time, sig, exp, got);
        end
    endtask

    // ==================================================
    // masters
    // ==================================================
    task automatic issue_bursts(input int ch);
        int beats;
        logic [id_w-1:0]   id;
        logic [size_w-1:0] size;
        logic [addr_w-1:0] base;
        for (int n = 0; n < bursts_per_master; n++) begin
            @(negedge aclk);
            if ($urandom_range(3) == 0) begin
                arvalid[ch] = 1'b0;
                @(negedge aclk);
            end
            beats = $urandom_range(max_beats, 1);
            id = id_w'($urandom);
            size = size_w'($urandom_range(3));
            base = {$urandom, $urandom} & ~64'h7;
            arid[ch] = id;
            araddr[ch] = base;
            arlen[ch] = len_w'(beats - 1);
            arsize[ch] = size;
            arvalid[ch] = 1'b1;
            #1;
            while (!arready[ch]) begin
                @(negedge aclk);
                #1;
            end
            cmd_q.push_back({id, len_w'(beats - 1), size, base});
            for (int k = 0; k < beats; k++) begin
                if (ch == 0) exp_knl.push_back({id, k == beats - 1, base + k});
                else exp_mmu.push_back({id, k == beats - 1, base + k});
            end
            @(posedge aclk);
        end
        @(negedge aclk);
        arvalid[ch] = 1'b0;
    endtask

    task automatic check_returns(input int ch);
        logic [68:0] exp;
        string name;
        name = (ch == 0) ? "knl" : "mmu";
        forever begin
            @(negedge aclk);
            rready[ch] = (ch == 0 && hold_knl) ? 1'b0 : ($urandom_range(3) != 0);
            #1;
            if (rvalid[ch] && rready[ch]) begin
                if ((ch == 0 && exp_knl.size() == 0) || (ch == 1 && exp_mmu.size() == 0)) begin
                    errors++;
                    $display("%s returned a beat that was never requested", name);
                end else begin
                    exp = (ch == 0) ? exp_knl.pop_front() : exp_mmu.pop_front();
                    check_field({name, "_rid"}, 64'(exp[68:65]), 64'(rid[ch]));
                    check_field({name, "_rlast"}, 64'(exp[64]), 64'(rlast[ch]));
                    check_field({name, "_rdata"}, exp[63:0], rdata[ch]);
                    check_field({name, "_rresp"}, 64'(resp_okay), 64'(rresp[ch]));
                end
            end
        end
    endtask

    // ==================================================
    // DDR model
    // ==================================================
    task automatic ddr_accept();
        logic [78:0] exp;
        forever begin
            @(negedge aclk);
            ddr_arready = ($urandom_range(99) < 70);
            #1;
            if (ddr_arvalid && ddr_arready) begin
                if (cmd_q.size() == 0) begin
                    errors++;
                    $display("ddr address transfer with no accepted command");
                end else begin
                    exp = cmd_q.pop_front();
                    check_field("ddr_arid", 64'(exp[78:75]), 64'(ddr_arid));
                    check_field("ddr_arlen", 64'(exp[74:67]), 64'(ddr_arlen));
                    check_field("ddr_arsize", 64'(exp[66:64]), 64'(ddr_arsize));
                    check_field("ddr_araddr", exp[63:0], ddr_araddr);
                end
                burst_q.push_back({ddr_arid, ddr_arlen, ddr_araddr});
            end
        end
    endtask

    task automatic ddr_return();
        int   k = 0;
        logic fired = 1'b0;
        forever begin
            @(negedge aclk);
            if (fired) begin
                ddr_rvalid = 1'b0;
                if (ddr_rlast) begin
                    void'(burst_q.pop_front());
                    k = 0;
                end else begin
                    k++;
                end
            end
            if (!ddr_rvalid && burst_q.size() > 0 && $urandom_range(3) != 0) begin
                ddr_rid = burst_q[0][75:72];
                ddr_rdata = burst_q[0][63:0] + k;
                ddr_rresp = resp_okay;
                ddr_rlast = (k == int'(burst_q[0][71:64]));
                ddr_rvalid = 1'b1;
            end
            #1;
            fired = ddr_rvalid && ddr_rready;
        end
    endtask

    // long knl stall while mmu keeps going
    task automatic stall_knl();
        logic saw_low;
        saw_low = 1'b0;
        repeat (100) @(negedge aclk);
        hold_knl = 1'b1;
        repeat (knl_hold_cycles) begin
            @(negedge aclk);
            if (!ddr_rready) begin
                saw_low = 1'b1;
            end
        end
        hold_knl = 1'b0;
        if (!saw_low) begin
            errors++;
            $display("ddr_rready never dropped while knl_rready was held low");
        end
    endtask

    // ==================================================
    // main sequence and watchdog
    // ==================================================
    initial begin
        int total;
        areset = 1'b1;
        arvalid = '0;
        arid = '0;
        araddr = '0;
        arlen = '0;
        arsize = '0;
        rready = '0;
        ddr_arready = 1'b0;
        ddr_rvalid = 1'b0;
        ddr_rid = '0;
        ddr_rdata = '0;
        ddr_rresp = '0;
        ddr_rlast = 1'b0;
        void'($urandom(seed));
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        areset = 1'b0;
        fork
            check_returns(0);
            check_returns(1);
            ddr_accept();
            ddr_return();
            stall_knl();
        join_none
        fork
            issue_bursts(0);
            issue_bursts(1);
        join
        while (exp_knl.size() > 0 || exp_mmu.size() > 0) @(negedge aclk);
        repeat (10) @(negedge aclk);
        total = errors + u_rd_mux_top.u_rd_mux_asserts.fail_count;
        $display("summary: %0d scoreboard errors, %0d assertion failures",
                 errors, u_rd_mux_top.u_rd_mux_asserts.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout: bursts still outstanding after %0d ns", watchdog_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* rd_mux.f */
logic/rd_mux_pkg.sv
logic/sync_fifo.sv
logic/ar_arbiter.sv
logic/ar_issue.sv
logic/r_router.sv
logic/rd_mux_top.sv
bench/tb_clock.sv
bench/rd_mux_asserts.sv
bench/rd_mux_tb.sv

/* run.sh */
#!/bin/sh
# build and run the read-port concentrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module rd_mux_tb \
    -f rd_mux.f \
    -Mdir obj_dir \
    -o rd_mux_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rd_mux_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -q "^TEST PASSED$"; then
    exit 0
fi

echo "pass message not found"
exit 1
